//--- common/supervisor_consts.svh
`ifndef SUPERVISOR_CONSTS_SVH
`define SUPERVISOR_CONSTS_SVH

//==================================================
// timing
//==================================================

// default tick period in clock cycles (3 to 255)
`define SUP_TCK_SCALE 20

//==================================================
// control word at 38h
//==================================================

// stop on error
`define SUP_CFG_SOE_BIT 21
// error report enable
`define SUP_CFG_ER_BIT 20

//==================================================
// message rate word at 39h, task word at 3Bh
//==================================================

// lowest bit of the 8-bit message count field
`define SUP_MSGCNT_LSB 16
// lowest bit of the 2-bit privilege level field
`define SUP_CPL_LSB 18

// refill timer and message counter widths
`define SUP_TIMER_W 16
`define SUP_MSGCNT_W 8

`endif

//--- common/supervisor_pkg.sv
`default_nettype none

package supervisor_pkg;

	// portal configuration register map
	typedef enum logic [5:0]
	{
		CfgCtrl    = 6'h38,
		CfgMsgRate = 6'h39,
		CfgTask    = 6'h3B,
		CfgPso     = 6'h3C
	} cfgAddrT;

	// interrupt sequencer states
	typedef enum logic [1:0]
	{
		IntIdle    = 2'd0,
		IntPending = 2'd1,
		IntIssued  = 2'd2,
		IntWaitAck = 2'd3
	} intStateT;

	// process selector
	typedef logic [23:0] selectorT;

	// task identifier
	typedef logic [15:0] taskIdT;

	// privilege level
	typedef logic [1:0] cplT;

	// configuration data word
	typedef logic [31:0] cfgWordT;

endpackage

`default_nettype wire

//--- portal/PortalControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "supervisor_consts.svh"

module PortalControl (
	input wire EXTCLK,
	input wire RST,
	input wire CfgStb,
	input wire supervisor_pkg::cfgAddrT CfgAddr,
	input wire supervisor_pkg::cfgWordT CfgData,
	input wire PortalReady,
	input wire PortalActivation,
	input wire supervisor_pkg::taskIdT CsrTaskId,
	input wire supervisor_pkg::cplT CsrCpl,
	input wire supervisor_pkg::selectorT Cpsr,
	input wire PortalMcEstb,
	input wire PortalDis,
	input wire PortalRun,
	output supervisor_pkg::cplT PortalCpl,
	output supervisor_pkg::taskIdT PortalTaskId,
	output supervisor_pkg::selectorT PortalPso,
	output supervisor_pkg::cfgWordT PortalState,
	output logic PortalErrStb,
	output logic PortalRst,
	output logic PortalLocked,
	output logic MsgRateStb,
	output logic [`SUP_MSGCNT_W-1:0] MsgCntBase,
	output logic [`SUP_TIMER_W-1:0] TimerBase
);

	logic wrCtrl;
	logic wrTask;
	logic wrPso;
	logic activate;
	logic soeFlag;
	logic erFlag;
	logic [15:0] cfgScratch;
	supervisor_pkg::cfgWordT stateWord;

	//==================================================
	// write decode
	//==================================================
	assign wrCtrl = CfgStb && (CfgAddr == supervisor_pkg::CfgCtrl);
	assign wrTask = CfgStb && (CfgAddr == supervisor_pkg::CfgTask);
	assign wrPso = CfgStb && (CfgAddr == supervisor_pkg::CfgPso);
	assign activate = PortalReady & PortalActivation;

	// rate word goes straight to the throttle
	assign MsgRateStb = CfgStb && (CfgAddr == supervisor_pkg::CfgMsgRate);
	assign MsgCntBase = CfgData[`SUP_MSGCNT_LSB +: `SUP_MSGCNT_W];
	assign TimerBase = CfgData[`SUP_TIMER_W-1:0];

	// control word flags with error reporting on after reset
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
		begin
			soeFlag <= 1'b0;
			erFlag <= 1'b1;
			cfgScratch <= 16'd0;
		end
		else if (wrCtrl)
		begin
			soeFlag <= CfgData[`SUP_CFG_SOE_BIT];
			erFlag <= CfgData[`SUP_CFG_ER_BIT];
			cfgScratch <= CfgData[15:0];
		end
	end

	//==================================================
	// portal context
	//==================================================

	// a config write wins over an activation in the same cycle
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
		begin
			PortalCpl <= '0;
			PortalTaskId <= '0;
		end
		else if (wrTask)
		begin
			PortalCpl <= CfgData[`SUP_CPL_LSB +: 2];
			PortalTaskId <= CfgData[15:0];
		end
		else if (activate)
		begin
			PortalCpl <= CsrCpl;
			PortalTaskId <= CsrTaskId;
		end
	end

	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			PortalPso <= '0;
		else if (wrPso)
			PortalPso <= CfgData[23:0];
		else if (activate)
			PortalPso <= Cpsr;
	end

	// readback mux
	always_comb
	begin
		stateWord = '0;
		case (CfgAddr)
			supervisor_pkg::CfgPso:
				stateWord[23:0] = PortalPso;
			supervisor_pkg::CfgTask:
			begin
				stateWord[`SUP_CPL_LSB +: 2] = PortalCpl;
				stateWord[15:0] = PortalTaskId;
			end
			default:
				stateWord[15:0] = cfgScratch;
		endcase
	end

	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			PortalState <= '0;
		else
			PortalState <= stateWord;
	end

	//==================================================
	// error handling
	//==================================================

	// error report stays quiet in reset
	assign PortalErrStb = PortalMcEstb & erFlag & RST;

	// one-cycle portal reset on an error with stop-on-error set
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			PortalRst <= 1'b0;
		else
			PortalRst <= !(PortalMcEstb && soeFlag);
	end

	// datapath lock, released by a portal run
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			PortalLocked <= 1'b0;
		else
			PortalLocked <= (PortalLocked | PortalDis | (PortalMcEstb & soeFlag)) & ~PortalRun;
	end

endmodule

`default_nettype wire

//--- portal/PortalMsgThrottle.sv
`timescale 1ns/1ps
`default_nettype none
`include "supervisor_consts.svh"

module PortalMsgThrottle (
	input wire EXTCLK,
	input wire RST,
	input wire Tick,
	input wire CfgRst,
	input wire MsgRateStb,
	input wire [`SUP_MSGCNT_W-1:0] MsgCntBase,
	input wire [`SUP_TIMER_W-1:0] TimerBase,
	input wire PortalSmsg,
	output logic PortalSmsgOut
);

	logic [`SUP_MSGCNT_W-1:0] cntBase;
	logic [`SUP_MSGCNT_W-1:0] msgCnt;
	logic [`SUP_TIMER_W-1:0] timerBase;
	logic [`SUP_TIMER_W-1:0] msgTimer;
	logic msgEnable;
	logic cntLive;
	logic timerDone;

	assign cntLive = |msgCnt;
	assign timerDone = ~|msgTimer;

	// rate bases
	always_ff @(posedge EXTCLK)
	begin
		if (!RST || CfgRst)
		begin
			cntBase <= '0;
			timerBase <= '0;
		end
		else if (MsgRateStb)
		begin
			cntBase <= MsgCntBase;
			timerBase <= TimerBase;
		end
	end

	// token counter and refill timer
	always_ff @(posedge EXTCLK)
	begin
		if (!RST || CfgRst)
		begin
			msgCnt <= '0;
			msgTimer <= '0;
		end
		else if (timerDone)
		begin
			msgCnt <= cntBase;
			msgTimer <= timerBase;
		end
		else
		begin
			if (PortalSmsgOut)
				msgCnt <= msgCnt - 1'b1;
			// timer only runs once a token has been used
			if (Tick && (msgCnt != cntBase))
				msgTimer <= msgTimer - 1'b1;
		end
	end

	// enable for the next offered message
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			msgEnable <= 1'b0;
		else
			msgEnable <= cntLive;
	end

	assign PortalSmsgOut = PortalSmsg & RST & msgEnable & cntLive;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module CoreSupervisorTb -f vlog.f
out=$(./obj_dir/VCoreSupervisorTb) || true
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

//--- verification/CoreSupervisorTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "supervisor_consts.svh"

module CoreSupervisorTb;

	localparam int TckScale = `SUP_TCK_SCALE;
	localparam int ResetCycles = 5;
	// resets, context, throttle, errors, interrupts
	localparam int PhaseLen [1:5] = '{300, 300, 400, 300, 400};
	localparam int TimeoutCycles = 2 * (ResetCycles + PhaseLen[1] + PhaseLen[2]
		+ PhaseLen[3] + PhaseLen[4] + PhaseLen[5]);

	logic EXTCLK = 1'b0;
	logic EXTRESET, MsgrReset, ContReset;
	logic CfgStb, CfgRst;
	supervisor_pkg::cfgAddrT CfgAddr;
	supervisor_pkg::cfgWordT CfgData;
	logic PortalReady, PortalActivation;
	supervisor_pkg::taskIdT CsrTaskId;
	supervisor_pkg::cplT CsrCpl;
	supervisor_pkg::selectorT Cpsr;
	logic PortalSmsg, PortalMcEstb, PortalDis, PortalRun;
	logic IntEnable, IntReq, IntAck, CoreEmpty, CoreSmsgBkpt;
	wire RST, Tick, CoreStop, MsgrIntReq;
	supervisor_pkg::cplT PortalCpl;
	supervisor_pkg::taskIdT PortalTaskId;
	supervisor_pkg::selectorT PortalPso;
	supervisor_pkg::cfgWordT PortalState;
	wire PortalErrStb, PortalRst, PortalLocked, PortalSmsgOut;

	integer seed = 32'h04c09b75;
	int checks = 0;
	int errors = 0;
	int cycleCount = 0;
	logic checkOn = 1'b0;

	// reference model state after the last rising edge
	logic mRst = 1'b0;
	logic mTick;
	int runCycles;
	supervisor_pkg::intStateT mInt;
	logic mSoe, mEr, mPortalRst, mLocked, mMsgEn;
	logic [15:0] mScratch;
	supervisor_pkg::cplT mCpl;
	supervisor_pkg::taskIdT mTask;
	supervisor_pkg::selectorT mPso;
	supervisor_pkg::cfgWordT mState;
	logic [7:0] mCntBase, mMsgCnt;
	logic [15:0] mTimerBase, mTimer;

	CoreSupervisor UUT (.*);

	always #2 EXTCLK = ~EXTCLK;

	//==================================================
	// compare tasks
	//==================================================
	task automatic logicCheck(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic cplCheck(input string name, input supervisor_pkg::cplT got,
		input supervisor_pkg::cplT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic taskIdCheck(input string name, input supervisor_pkg::taskIdT got,
		input supervisor_pkg::taskIdT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic selectorCheck(input string name, input supervisor_pkg::selectorT got,
		input supervisor_pkg::selectorT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic wordCheck(input string name, input supervisor_pkg::cfgWordT got,
		input supervisor_pkg::cfgWordT exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	//==================================================
	// reference model
	//==================================================

	// a message passes only with tokens left and the gate open
	function automatic logic msgAllowed();
		return PortalSmsg & mRst & mMsgEn & (mMsgCnt != 8'd0);
	endfunction

	task automatic compareOutputs();
		logicCheck("RST", RST, mRst);
		logicCheck("Tick", Tick, mTick);
		logicCheck("CoreStop", CoreStop, mInt != supervisor_pkg::IntIdle);
		logicCheck("MsgrIntReq", MsgrIntReq, mInt == supervisor_pkg::IntIssued);
		cplCheck("PortalCpl", PortalCpl, mCpl);
		taskIdCheck("PortalTaskId", PortalTaskId, mTask);
		selectorCheck("PortalPso", PortalPso, mPso);
		wordCheck("PortalState", PortalState, mState);
		logicCheck("PortalErrStb", PortalErrStb, PortalMcEstb & mEr & mRst);
		logicCheck("PortalRst", PortalRst, mPortalRst);
		logicCheck("PortalLocked", PortalLocked, mLocked);
		logicCheck("PortalSmsgOut", PortalSmsgOut, msgAllowed());
	endtask

	// next rising edge, from the inputs that it will sample
	task automatic advanceModel();
		logic rstAll;
		logic sent;
		logic activate;
		rstAll = EXTRESET & MsgrReset & ContReset;
		sent = msgAllowed();
		activate = PortalReady & PortalActivation;
		// throttle terms all use the old counter
		mMsgEn = mRst & (mMsgCnt != 8'd0);
		if (!mRst || CfgRst)
		begin
			mMsgCnt = 8'd0;
			mTimer = 16'd0;
		end
		else if (mTimer == 16'd0)
		begin
			mMsgCnt = mCntBase;
			mTimer = mTimerBase;
		end
		else
		begin
			if (mTick && (mMsgCnt != mCntBase))
				mTimer = mTimer - 16'd1;
			if (sent)
				mMsgCnt = mMsgCnt - 8'd1;
		end
		if (!mRst || CfgRst)
		begin
			mCntBase = 8'd0;
			mTimerBase = 16'd0;
		end
		else if (CfgStb && CfgAddr == supervisor_pkg::CfgMsgRate)
		begin
			mCntBase = CfgData[`SUP_MSGCNT_LSB +: 8];
			mTimerBase = CfgData[15:0];
		end
		// tick every TckScale cycles of released reset
		runCycles = (!mRst || !rstAll) ? 0 : runCycles + 1;
		mTick = (runCycles != 0) && (runCycles % TckScale == 0);
		// interrupt sequence
		if (!mRst || !IntEnable || IntAck)
			mInt = supervisor_pkg::IntIdle;
		else if (mInt == supervisor_pkg::IntIdle && IntReq)
			mInt = supervisor_pkg::IntPending;
		else if (mInt == supervisor_pkg::IntPending && CoreEmpty && !CoreSmsgBkpt)
			mInt = supervisor_pkg::IntIssued;
		else if (mInt == supervisor_pkg::IntIssued)
			mInt = supervisor_pkg::IntWaitAck;
		// readback sees the old context
		if (!mRst)
			mState = '0;
		else if (CfgAddr == supervisor_pkg::CfgPso)
			mState = {8'd0, mPso};
		else if (CfgAddr == supervisor_pkg::CfgTask)
			mState = {12'd0, mCpl, 2'd0, mTask};
		else
			mState = {16'd0, mScratch};
		if (!mRst)
		begin
			mCpl = '0;
			mTask = '0;
			mPso = '0;
		end
		else
		begin
			if (CfgStb && CfgAddr == supervisor_pkg::CfgTask)
			begin
				mCpl = CfgData[`SUP_CPL_LSB +: 2];
				mTask = CfgData[15:0];
			end
			else if (activate)
			begin
				mCpl = CsrCpl;
				mTask = CsrTaskId;
			end
			if (CfgStb && CfgAddr == supervisor_pkg::CfgPso)
				mPso = CfgData[23:0];
			else if (activate)
				mPso = Cpsr;
		end
		// error path before SoE changes
		mPortalRst = mRst && !(PortalMcEstb && mSoe);
		mLocked = mRst && (mLocked || PortalDis || (PortalMcEstb && mSoe)) && !PortalRun;
		if (!mRst)
		begin
			mSoe = 1'b0;
			mEr = 1'b1;
			mScratch = 16'd0;
		end
		else if (CfgStb && CfgAddr == supervisor_pkg::CfgCtrl)
		begin
			mSoe = CfgData[`SUP_CFG_SOE_BIT];
			mEr = CfgData[`SUP_CFG_ER_BIT];
			mScratch = CfgData[15:0];
		end
		mRst = rstAll;
	endtask

	always @(negedge EXTCLK)
	begin
		if (checkOn)
			compareOutputs();
		advanceModel();
	end

	//==================================================
	// stimulus
	//==================================================
	function automatic supervisor_pkg::cfgAddrT pickAddr(input int phase,
		input logic [1:0] sel, input logic [5:0] raw);
		if (phase == 3)
			return supervisor_pkg::CfgMsgRate;
		case (sel)
			2'd0: return supervisor_pkg::CfgTask;
			2'd1: return supervisor_pkg::CfgPso;
			2'd2: return supervisor_pkg::CfgCtrl;
			default: return supervisor_pkg::cfgAddrT'(raw);
		endcase
	endfunction

	// phase 0 holds EXTRESET low
	// phase 3 keeps the rate word small
	task automatic driveCycle(input int phase);
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] e;
		r = $random(seed);
		d = $random(seed);
		e = $random(seed);
		EXTRESET <= (phase != 0) && !(phase == 1 && r[5:0] == 6'd0);
		MsgrReset <= !(phase == 1 && r[11:6] == 6'd0);
		ContReset <= !(phase == 1 && r[17:12] == 6'd0);
		CfgStb <= (phase == 3) ? (r[22:18] == 5'd0) : (r[19:18] == 2'd0);
		CfgAddr <= pickAddr(phase, r[21:20], d[5:0]);
		CfgData <= (phase == 3) ? {13'd0, d[18:17], 1'b1, 14'd0, d[1:0]} : d;
		CfgRst <= (phase == 3) && (r[30:24] == 7'd0);
		PortalReady <= r[24];
		PortalActivation <= (phase == 2) && r[25];
		CsrTaskId <= d[31:16];
		CsrCpl <= d[7:6];
		Cpsr <= {d[15:0], r[31:24]};
		PortalSmsg <= r[26];
		// error strobes never back to back, some during the reset phase
		PortalMcEstb <= (phase == 1 || phase == 4) && r[27] && !PortalMcEstb;
		PortalDis <= (phase == 4) && (r[29:28] == 2'd0);
		PortalRun <= (phase == 4) && (r[31:29] == 3'd0);
		IntEnable <= (phase == 5) ? (e[4:0] != 5'd0) : e[5];
		IntReq <= (phase == 5) && (e[8:6] == 3'd0);
		IntAck <= (phase == 5) && (e[12:9] == 4'd0);
		CoreEmpty <= e[13];
		CoreSmsgBkpt <= (e[15:14] == 2'd0);
	endtask

	always @(posedge EXTCLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > TimeoutCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial
	begin
		driveCycle(0);
		repeat (ResetCycles - 1)
		begin
			@(posedge EXTCLK);
			driveCycle(0);
		end
		checkOn = 1'b1;
		for (int phase = 1; phase <= 5; phase++)
		begin
			for (int i = 0; i < PhaseLen[phase]; i++)
			begin
				@(posedge EXTCLK);
				driveCycle(phase);
				// throttle phase opens with a rate write
				if (phase == 3 && i == 0)
					CfgStb <= 1'b1;
			end
		end
		repeat (2) @(posedge EXTCLK);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/CoreSupervisor_properties.sv
`timescale 1ns/1ps
`default_nettype none

module CoreSupervisorProperties (
	input wire EXTCLK,
	input wire RST,
	input wire Tick,
	input wire MsgrIntReq,
	input wire PortalRst,
	input wire PortalSmsg,
	input wire PortalSmsgOut
);

	// messenger request is a single pulse
	msgrPulse: assert property (@(posedge EXTCLK) disable iff (!RST)
		MsgrIntReq |=> !MsgrIntReq)
		else $error("MsgrIntReq held high for more than one cycle");

	// portal reset drops for one cycle only
	portalRstPulse: assert property (@(posedge EXTCLK) disable iff (!RST)
		$fell(PortalRst) |=> PortalRst)
		else $error("PortalRst held low for more than one cycle");

	tickInReset: assert property (@(posedge EXTCLK) !RST |-> !Tick)
		else $error("Tick pulsed while RST was low");

	// no message out without an offer
	smsgGate: assert property (@(posedge EXTCLK) !PortalSmsg |-> !PortalSmsgOut)
		else $error("PortalSmsgOut high while PortalSmsg was low");

endmodule

bind CoreSupervisor CoreSupervisorProperties props (
	.EXTCLK(EXTCLK),
	.RST(RST),
	.Tick(Tick),
	.MsgrIntReq(MsgrIntReq),
	.PortalRst(PortalRst),
	.PortalSmsg(PortalSmsg),
	.PortalSmsgOut(PortalSmsgOut)
);

`default_nettype wire

//--- verilog/CoreSupervisor.sv
`timescale 1ns/1ps
`default_nettype none
`include "supervisor_consts.svh"

module CoreSupervisor #(
	parameter int TckScale = `SUP_TCK_SCALE
)(
	input wire EXTCLK,
	// reset sources
	input wire EXTRESET,
	input wire MsgrReset,
	input wire ContReset,
	// configuration
	input wire CfgStb,
	input wire supervisor_pkg::cfgAddrT CfgAddr,
	input wire supervisor_pkg::cfgWordT CfgData,
	input wire CfgRst,
	// portal activation and core state
	input wire PortalReady,
	input wire PortalActivation,
	input wire supervisor_pkg::taskIdT CsrTaskId,
	input wire supervisor_pkg::cplT CsrCpl,
	input wire supervisor_pkg::selectorT Cpsr,
	// portal events
	input wire PortalSmsg,
	input wire PortalMcEstb,
	input wire PortalDis,
	input wire PortalRun,
	// interrupt path
	input wire IntEnable,
	input wire IntReq,
	input wire IntAck,
	input wire CoreEmpty,
	input wire CoreSmsgBkpt,
	output wire RST,
	output wire Tick,
	output wire CoreStop,
	output wire MsgrIntReq,
	output wire supervisor_pkg::cplT PortalCpl,
	output wire supervisor_pkg::taskIdT PortalTaskId,
	output wire supervisor_pkg::selectorT PortalPso,
	output wire supervisor_pkg::cfgWordT PortalState,
	output wire PortalErrStb,
	output wire PortalRst,
	output wire PortalLocked,
	output wire PortalSmsgOut
);

	// rate settings from the config block to the throttle
	wire msgRateStb;
	wire [`SUP_MSGCNT_W-1:0] msgCntBase;
	wire [`SUP_TIMER_W-1:0] timerBase;

	//==================================================
	// reset and tick
	//==================================================
	ResetTickUnit #(.TckScale(TckScale)) resetTick (
		.EXTCLK(EXTCLK), .EXTRESET(EXTRESET), .MsgrReset(MsgrReset), .ContReset(ContReset),
		.RST(RST), .Tick(Tick)
	);

	//==================================================
	// interrupt sequencer
	//==================================================
	InterruptSequencer intSeq (
		.EXTCLK(EXTCLK), .RST(RST), .IntEnable(IntEnable), .IntReq(IntReq), .IntAck(IntAck),
		.CoreEmpty(CoreEmpty), .CoreSmsgBkpt(CoreSmsgBkpt),
		.CoreStop(CoreStop), .MsgrIntReq(MsgrIntReq)
	);

	//==================================================
	// portal configuration and errors
	//==================================================
	PortalControl portalCtrl (
		.EXTCLK(EXTCLK), .RST(RST), .CfgStb(CfgStb), .CfgAddr(CfgAddr), .CfgData(CfgData),
		.PortalReady(PortalReady), .PortalActivation(PortalActivation),
		.CsrTaskId(CsrTaskId), .CsrCpl(CsrCpl), .Cpsr(Cpsr),
		.PortalMcEstb(PortalMcEstb), .PortalDis(PortalDis), .PortalRun(PortalRun),
		.PortalCpl(PortalCpl), .PortalTaskId(PortalTaskId), .PortalPso(PortalPso),
		.PortalState(PortalState), .PortalErrStb(PortalErrStb), .PortalRst(PortalRst),
		.PortalLocked(PortalLocked), .MsgRateStb(msgRateStb), .MsgCntBase(msgCntBase),
		.TimerBase(timerBase)
	);

	// message rate limiter
	PortalMsgThrottle msgThrottle (
		.EXTCLK(EXTCLK), .RST(RST), .Tick(Tick), .CfgRst(CfgRst),
		.MsgRateStb(msgRateStb), .MsgCntBase(msgCntBase), .TimerBase(timerBase),
		.PortalSmsg(PortalSmsg), .PortalSmsgOut(PortalSmsgOut)
	);

endmodule

`default_nettype wire

//--- verilog/InterruptSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module InterruptSequencer (
	input wire EXTCLK,
	input wire RST,
	input wire IntEnable,
	input wire IntReq,
	input wire IntAck,
	input wire CoreEmpty,
	input wire CoreSmsgBkpt,
	output logic CoreStop,
	output logic MsgrIntReq
);

	supervisor_pkg::intStateT intState;
	supervisor_pkg::intStateT intNext;

	// next state
	always_comb
	begin
		intNext = intState;
		// ack or disable aborts the sequence
		if (!IntEnable || IntAck)
			intNext = supervisor_pkg::IntIdle;
		else
		begin
			case (intState)
				supervisor_pkg::IntIdle:
				begin
					if (IntReq)
						intNext = supervisor_pkg::IntPending;
				end
				supervisor_pkg::IntPending:
				begin
					// core drained and not parked on a message breakpoint
					if (CoreEmpty && !CoreSmsgBkpt)
						intNext = supervisor_pkg::IntIssued;
				end
				supervisor_pkg::IntIssued:
					intNext = supervisor_pkg::IntWaitAck;
				supervisor_pkg::IntWaitAck:
					intNext = supervisor_pkg::IntWaitAck;
				default:
					intNext = supervisor_pkg::IntIdle;
			endcase
		end
	end

	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
			intState <= supervisor_pkg::IntIdle;
		else
			intState <= intNext;
	end

	// core stays stopped until the messenger acknowledges
	assign CoreStop = (intState != supervisor_pkg::IntIdle);
	assign MsgrIntReq = (intState == supervisor_pkg::IntIssued);

endmodule

`default_nettype wire

//--- verilog/ResetTickUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "supervisor_consts.svh"

module ResetTickUnit #(
	parameter int TckScale = `SUP_TCK_SCALE
)(
	input wire EXTCLK,
	input wire EXTRESET,
	input wire MsgrReset,
	input wire ContReset,
	output logic RST,
	output logic Tick
);

	// counter value in the cycle before a tick
	localparam logic [7:0] TickLast = 8'(TckScale - 1);

	logic rstAll;
	logic [7:0] tickCnt;

	// all three sources must be released
	assign rstAll = EXTRESET & MsgrReset & ContReset;

	// registered system reset
	always_ff @(posedge EXTCLK)
	begin
		RST <= rstAll;
	end

	// tick generator
	// also held off by the incoming reset, so no tick lands in the first reset cycle
	always_ff @(posedge EXTCLK)
	begin
		if (!RST || !rstAll)
		begin
			tickCnt <= 8'd0;
			Tick <= 1'b0;
		end
		else if (tickCnt == TickLast)
		begin
			tickCnt <= 8'd0;
			Tick <= 1'b1;
		end
		else
		begin
			tickCnt <= tickCnt + 8'd1;
			Tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/supervisor_pkg.sv
verilog/ResetTickUnit.sv
verilog/InterruptSequencer.sv
portal/PortalControl.sv
portal/PortalMsgThrottle.sv
verilog/CoreSupervisor.sv
verification/CoreSupervisor_properties.sv
verification/CoreSupervisorTb.sv
